/* Makefile */
SOURCES := $(wildcard verilog/*.sv) verilog/bridge_settings.svh tb/cdc_bridge_tb.sv

.PHONY: all run clean

all: run

obj_dir/Vcdc_bridge_tb: sim.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module cdc_bridge_tb -o Vcdc_bridge_tb

run: obj_dir/Vcdc_bridge_tb
	./obj_dir/Vcdc_bridge_tb | tee sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

/* sim.f */
+incdir+verilog
verilog/cdc_ptr_pkg.sv
verilog/bridge_payload_pkg.sv
verilog/dual_port_ram.sv
verilog/wr_ptr_ctrl.sv
verilog/rd_ptr_ctrl.sv
verilog/async_fifo.sv
verilog/cdc_bridge.sv
tb/cdc_bridge_tb.sv

/* tb/cdc_bridge_tb.sv */
`include "bridge_settings.svh"

module cdc_bridge_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // Rough length of all tests in cycles for the watchdog
  localparam int TEST_CYCLES = 1600;

  logic wr_clk;
  logic rd_clk;
  logic rd_rst_n;
  logic sample_wr_en;
  logic sample_rd_en;
  logic event_wr_en;
  logic event_rd_en;
  logic sample_full;
  logic sample_afull;
  logic sample_empty;
  logic sample_aempty;
  logic event_full;
  logic event_afull;
  logic event_empty;
  logic event_aempty;
  bridge_payload_pkg::sample_t sample_wr_data;
  bridge_payload_pkg::sample_t sample_rd_data;
  bridge_payload_pkg::event_t  event_wr_data;
  bridge_payload_pkg::event_t  event_rd_data;

  // Reference queues and pending read checks
  bridge_payload_pkg::sample_t sample_q[$];
  bridge_payload_pkg::event_t  event_q[$];
  bridge_payload_pkg::sample_t sample_exp;
  bridge_payload_pkg::event_t  event_exp;
  logic sample_due;
  logic event_due;
  int   sample_reads;
  int   errors;
  int   test_errors;
  int   tests_passed;
  int   tests_failed;

  cdc_bridge cdc_bridge_inst (.*);

  initial begin
    wr_clk = 1'b0;
    forever #5 wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #7 rd_clk = ~rd_clk;
  end

  initial begin
    #(TEST_CYCLES * 14 + 1000);
    $display("Timeout: the tests did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

  task automatic flag_error(input string msg);
    $display("%0t: %s", $time, msg);
    errors++;
  endtask

  task automatic data_error(input string fifo, input logic [31:0] exp, input logic [31:0] got);
    $display("MISMATCH at %0t: %s rd_data expected %h, got %h", $time, fifo, exp, got);
    errors++;
  endtask

  function automatic bridge_payload_pkg::sample_t rand_sample();
    logic [31:0] r;
    r = $urandom();
    return r[19:0];
  endfunction

  function automatic bridge_payload_pkg::event_t rand_event();
    logic [31:0] r;
    r = $urandom();
    return r[14:0];
  endfunction

  // Write side model and full safety
  always @(posedge wr_clk) begin
    if (rd_rst_n) begin
      if (sample_q.size() >= `SAMPLE_FIFO_DEPTH)
        assert (sample_full) else flag_error("Sample FIFO was full but full was low");
      if (event_q.size() >= `EVENT_FIFO_DEPTH)
        assert (event_full) else flag_error("Event FIFO was full but full was low");
      if (sample_wr_en && !sample_full) sample_q.push_back(sample_wr_data);
      if (event_wr_en && !event_full) event_q.push_back(event_wr_data);
    end
  end

  // Read side model with data order and empty safety
  always @(posedge rd_clk) begin
    if (sample_due)
      assert (sample_rd_data == sample_exp) else data_error("sample", 32'(sample_exp), 32'(sample_rd_data));
    if (event_due)
      assert (event_rd_data == event_exp) else data_error("event", 32'(event_exp), 32'(event_rd_data));
    sample_due = 1'b0;
    event_due  = 1'b0;
    if (rd_rst_n) begin
      if (sample_q.size() == 0)
        assert (sample_empty) else flag_error("Sample FIFO was empty but empty was low");
      if (event_q.size() == 0)
        assert (event_empty) else flag_error("Event FIFO was empty but empty was low");
      if (sample_rd_en && !sample_empty) begin
        sample_reads++;
        if (sample_q.size() == 0) begin
          flag_error("Sample read accepted with nothing written");
        end else begin
          sample_exp = sample_q.pop_front();
          sample_due = 1'b1;
        end
      end
      if (event_rd_en && !event_empty) begin
        if (event_q.size() == 0) begin
          flag_error("Event read accepted with nothing written");
        end else begin
          event_exp = event_q.pop_front();
          event_due = 1'b1;
        end
      end
    end
  end

  task automatic finish_test(input string name);
    if (errors == test_errors) begin
      $display("Test %s: pass", name);
      tests_passed++;
    end else begin
      $display("Test %s: fail, %0d errors", name, errors - test_errors);
      tests_failed++;
    end
    test_errors = errors;
  endtask

  // Enough for both synchronizers and flag registers
  task automatic settle();
    repeat (6) @(posedge rd_clk);
  endtask

  task automatic check_reset_flags(input string when);
    assert (sample_empty && sample_aempty && !sample_full && !sample_afull)
      else flag_error({"Sample flags wrong ", when, " reset"});
    assert (event_empty && event_aempty && !event_full && !event_afull)
      else flag_error({"Event flags wrong ", when, " reset"});
  endtask

  task automatic check_thresholds();
    @(negedge wr_clk);
    assert (sample_afull == (sample_q.size() >= `SAMPLE_FIFO_AFULL))
      else flag_error("Sample afull does not match the stored count");
    assert (event_afull == (event_q.size() >= `EVENT_FIFO_AFULL))
      else flag_error("Event afull does not match the stored count");
    @(negedge rd_clk);
    assert (sample_aempty == (sample_q.size() <= `SAMPLE_FIFO_AEMPTY))
      else flag_error("Sample aempty does not match the stored count");
    assert (event_aempty == (event_q.size() <= `EVENT_FIFO_AEMPTY))
      else flag_error("Event aempty does not match the stored count");
  endtask

  task automatic write_burst(input int cycles, input logic samples, input logic events);
    repeat (cycles) begin
      @(posedge wr_clk);
      sample_wr_en   <= samples;
      sample_wr_data <= rand_sample();
      event_wr_en    <= events;
      event_wr_data  <= rand_event();
    end
    @(posedge wr_clk);
    sample_wr_en <= 1'b0;
    event_wr_en  <= 1'b0;
  endtask

  task automatic read_burst(input int cycles, input logic random);
    repeat (cycles) begin
      @(posedge rd_clk);
      sample_rd_en <= random ? ($urandom() % 3 != 0) : 1'b1;
      event_rd_en  <= random ? ($urandom() % 3 != 0) : 1'b1;
    end
    @(posedge rd_clk);
    sample_rd_en <= 1'b0;
    event_rd_en  <= 1'b0;
  endtask

  task automatic random_traffic(input int cycles);
    fork
      repeat (cycles) begin
        @(posedge wr_clk);
        sample_wr_en   <= ($urandom() % 2 == 0);
        sample_wr_data <= rand_sample();
        event_wr_en    <= ($urandom() % 4 == 0);
        event_wr_data  <= rand_event();
      end
      read_burst(cycles * 10 / 14, 1'b1);
    join
    write_burst(0, 1'b0, 1'b0);
  endtask

  task automatic drain_all();
    while (sample_q.size() != 0 || event_q.size() != 0) read_burst(1, 1'b0);
    settle();
  endtask

  initial begin
    int i;
    void'($urandom(32'hc398));
    rd_rst_n = 1'b0;
    sample_wr_en = 1'b0;
    sample_rd_en = 1'b0;
    event_wr_en = 1'b0;
    event_rd_en = 1'b0;
    sample_wr_data = '0;
    event_wr_data = '0;
    sample_due = 1'b0;
    event_due = 1'b0;
    {errors, test_errors, tests_passed, tests_failed, sample_reads} = '0;

    repeat (4) begin
      @(negedge wr_clk);
      check_reset_flags("during");
    end
    @(posedge wr_clk);
    rd_rst_n <= 1'b1;
    repeat (3) begin
      @(negedge rd_clk);
      check_reset_flags("after");
    end
    finish_test("reset_state");

    random_traffic(400);
    drain_all();
    finish_test("random_order");

    // Fill the sample FIFO past DEPTH with reads stalled
    @(posedge wr_clk);
    sample_wr_en   <= 1'b1;
    sample_wr_data <= rand_sample();
    for (i = 1; i <= `SAMPLE_FIFO_DEPTH + 2; i++) begin
      @(posedge wr_clk);
      sample_wr_data <= rand_sample();
      @(negedge wr_clk);
      if (i < `SAMPLE_FIFO_DEPTH)
        assert (!sample_full) else flag_error("Sample full rose before the FIFO filled");
      else
        assert (sample_full) else flag_error("Sample full did not rise on the last write");
    end
    write_burst(0, 1'b0, 1'b0);
    assert (sample_q.size() == `SAMPLE_FIFO_DEPTH)
      else flag_error("Writes were accepted while the sample FIFO was full");
    sample_reads = 0;
    drain_all();
    // Reads past the last entry must be refused
    read_burst(4, 1'b0);
    settle();
    assert (sample_reads == `SAMPLE_FIFO_DEPTH)
      else flag_error("Draining did not return exactly DEPTH samples");
    finish_test("full_refusal");

    repeat (6) begin
      write_burst($urandom_range(1, 18), 1'b1, 1'b1);
      settle();
      check_thresholds();
      read_burst($urandom_range(0, 12), 1'b0);
      settle();
      check_thresholds();
    end
    drain_all();
    finish_test("thresholds");

    fork
      write_burst(`EVENT_FIFO_DEPTH + 3, 1'b0, 1'b1);
      repeat (60) begin
        @(posedge rd_clk);
        sample_rd_en <= ($urandom() % 2 == 0);
      end
    join
    fork
      repeat (40) begin
        @(posedge wr_clk);
        sample_wr_en   <= ($urandom() % 2 == 0);
        sample_wr_data <= rand_sample();
      end
      repeat (40) begin
        @(posedge rd_clk);
        sample_rd_en <= ($urandom() % 2 == 0);
      end
    join
    write_burst(0, 1'b0, 1'b0);
    @(posedge rd_clk);
    sample_rd_en <= 1'b0;
    @(negedge wr_clk);
    assert (event_full && event_q.size() == `EVENT_FIFO_DEPTH)
      else flag_error("Event FIFO did not fill while samples streamed");
    drain_all();
    finish_test("independence");

    $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog/async_fifo.sv */
module async_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int DEPTH = 16,
  parameter int AFULL = DEPTH - 1,
  parameter int AEMPTY = 1
) (
  input  logic     wr_clk,
  input  logic     rd_clk,
  input  logic     rd_rst_n,
  input  logic     wr_en,
  input  payload_t wr_data,
  output logic     full,
  output logic     afull,
  input  logic     rd_en,
  output payload_t rd_data,
  output logic     empty,
  output logic     aempty
);

  localparam int ADDR_WIDTH = $clog2(DEPTH);

  logic                   write;
  logic                   read;
  logic [ADDR_WIDTH-1:0]  waddr;
  logic [ADDR_WIDTH-1:0]  raddr;
  cdc_ptr_pkg::gray_ptr_t wr_gray;
  cdc_ptr_pkg::gray_ptr_t rd_gray;

  wr_ptr_ctrl #(
    .DEPTH(DEPTH),
    .AFULL(AFULL)
  ) wr_ptr_ctrl_inst (
    .wr_clk  (wr_clk),
    .rd_rst_n(rd_rst_n),
    .wr_en   (wr_en),
    .rd_gray (rd_gray),
    .write   (write),
    .waddr   (waddr),
    .wr_gray (wr_gray),
    .full    (full),
    .afull   (afull)
  );

  rd_ptr_ctrl #(
    .DEPTH (DEPTH),
    .AEMPTY(AEMPTY)
  ) rd_ptr_ctrl_inst (
    .rd_clk  (rd_clk),
    .rd_rst_n(rd_rst_n),
    .rd_en   (rd_en),
    .wr_gray (wr_gray),
    .read    (read),
    .raddr   (raddr),
    .rd_gray (rd_gray),
    .empty   (empty),
    .aempty  (aempty)
  );

  dual_port_ram #(
    .payload_t(payload_t),
    .DEPTH    (DEPTH)
  ) dual_port_ram_inst (
    .wr_clk(wr_clk),
    .write (write),
    .waddr (waddr),
    .wdata (wr_data),
    .rd_clk(rd_clk),
    .read  (read),
    .raddr (raddr),
    .rdata (rd_data)
  );

endmodule

/* verilog/bridge_payload_pkg.sv */
package bridge_payload_pkg;

  localparam int CHANNEL_WIDTH   = 4;
  localparam int VALUE_WIDTH     = 16;
  localparam int CODE_WIDTH      = 3;
  localparam int TIMESTAMP_WIDTH = 12;

  // Sample record, 20 bits
  typedef struct packed {
    logic [CHANNEL_WIDTH-1:0] channel;
    logic [VALUE_WIDTH-1:0]   value;
  } sample_t;

  // Event record, 15 bits
  typedef struct packed {
    logic [CODE_WIDTH-1:0]      code;
    logic [TIMESTAMP_WIDTH-1:0] timestamp;
  } event_t;

endpackage

/* verilog/bridge_settings.svh */
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// Sample FIFO, power-of-two depth
`define SAMPLE_FIFO_DEPTH 16
// Write-side count at or above which afull is set
`define SAMPLE_FIFO_AFULL 14
// Read-side count at or below which aempty is set
`define SAMPLE_FIFO_AEMPTY 2

// Event FIFO, kept shallow
`define EVENT_FIFO_DEPTH 4
`define EVENT_FIFO_AFULL 3
`define EVENT_FIFO_AEMPTY 1

`endif

/* verilog/cdc_bridge.sv */
`include "bridge_settings.svh"

module cdc_bridge (
  input  logic                        wr_clk,
  input  logic                        rd_clk,
  input  logic                        rd_rst_n,
  input  logic                        sample_wr_en,
  input  bridge_payload_pkg::sample_t sample_wr_data,
  output logic                        sample_full,
  output logic                        sample_afull,
  input  logic                        sample_rd_en,
  output bridge_payload_pkg::sample_t sample_rd_data,
  output logic                        sample_empty,
  output logic                        sample_aempty,
  input  logic                        event_wr_en,
  input  bridge_payload_pkg::event_t  event_wr_data,
  output logic                        event_full,
  output logic                        event_afull,
  input  logic                        event_rd_en,
  output bridge_payload_pkg::event_t  event_rd_data,
  output logic                        event_empty,
  output logic                        event_aempty
);

  // Sample records
  async_fifo #(
    .payload_t(bridge_payload_pkg::sample_t),
    .DEPTH    (`SAMPLE_FIFO_DEPTH),
    .AFULL    (`SAMPLE_FIFO_AFULL),
    .AEMPTY   (`SAMPLE_FIFO_AEMPTY)
  ) sample_fifo_inst (
    .wr_clk  (wr_clk),
    .rd_clk  (rd_clk),
    .rd_rst_n(rd_rst_n),
    .wr_en   (sample_wr_en),
    .wr_data (sample_wr_data),
    .full    (sample_full),
    .afull   (sample_afull),
    .rd_en   (sample_rd_en),
    .rd_data (sample_rd_data),
    .empty   (sample_empty),
    .aempty  (sample_aempty)
  );

  // Event records
  async_fifo #(
    .payload_t(bridge_payload_pkg::event_t),
    .DEPTH    (`EVENT_FIFO_DEPTH),
    .AFULL    (`EVENT_FIFO_AFULL),
    .AEMPTY   (`EVENT_FIFO_AEMPTY)
  ) event_fifo_inst (
    .wr_clk  (wr_clk),
    .rd_clk  (rd_clk),
    .rd_rst_n(rd_rst_n),
    .wr_en   (event_wr_en),
    .wr_data (event_wr_data),
    .full    (event_full),
    .afull   (event_afull),
    .rd_en   (event_rd_en),
    .rd_data (event_rd_data),
    .empty   (event_empty),
    .aempty  (event_aempty)
  );

endmodule

/* verilog/cdc_ptr_pkg.sv */
package cdc_ptr_pkg;

  localparam int MAX_ADDR_WIDTH = 8;

  // One wrap bit above the widest address
  typedef logic [MAX_ADDR_WIDTH:0] ptr_t;
  typedef logic [MAX_ADDR_WIDTH:0] gray_ptr_t;

  function automatic gray_ptr_t bin2gray(ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray2bin(gray_ptr_t gray);
    ptr_t bin;
    bin[MAX_ADDR_WIDTH] = gray[MAX_ADDR_WIDTH];
    for (int i = MAX_ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

/* verilog/dual_port_ram.sv */
module dual_port_ram #(
  parameter type payload_t = logic [7:0],
  parameter int DEPTH = 16,
  localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
  input  logic                  wr_clk,
  input  logic                  write,
  input  logic [ADDR_WIDTH-1:0] waddr,
  input  payload_t              wdata,
  input  logic                  rd_clk,
  input  logic                  read,
  input  logic [ADDR_WIDTH-1:0] raddr,
  output payload_t              rdata
);

  payload_t mem [DEPTH];

  // Write port
  always_ff @(posedge wr_clk) begin
    if (write) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read, holds between accepted reads
  always_ff @(posedge rd_clk) begin
    if (read) begin
      rdata <= mem[raddr];
    end
  end

endmodule

/* verilog/rd_ptr_ctrl.sv */
module rd_ptr_ctrl #(
  parameter int DEPTH = 16,
  parameter int AEMPTY = 1,
  localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
  input  logic                   rd_clk,
  input  logic                   rd_rst_n,
  input  logic                   rd_en,
  input  cdc_ptr_pkg::gray_ptr_t wr_gray,
  output logic                   read,
  output logic [ADDR_WIDTH-1:0]  raddr,
  output cdc_ptr_pkg::gray_ptr_t rd_gray,
  output logic                   empty,
  output logic                   aempty
);

  logic [1:0]             rst_sync;
  logic                   rst_n;
  logic [ADDR_WIDTH:0]    rd_bin;
  logic [ADDR_WIDTH:0]    rd_bin_next;
  cdc_ptr_pkg::gray_ptr_t rd_gray_next;
  cdc_ptr_pkg::gray_ptr_t wr_gray_meta;
  cdc_ptr_pkg::gray_ptr_t wr_gray_sync;
  cdc_ptr_pkg::ptr_t      wr_bin_sync;
  logic [ADDR_WIDTH:0]    avail_next;
  logic                   empty_next;
  logic                   aempty_next;

  // Reset release into the rd_clk domain
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign rst_n = rst_sync[1];

  assign read         = rd_en & ~empty;
  assign raddr        = rd_bin[ADDR_WIDTH-1:0];
  assign rd_bin_next  = rd_bin + (ADDR_WIDTH+1)'(read);
  assign rd_gray_next = cdc_ptr_pkg::bin2gray(cdc_ptr_pkg::ptr_t'(rd_bin_next));
  assign wr_bin_sync  = cdc_ptr_pkg::gray2bin(wr_gray_sync);

  // Entries the read side can see after this cycle
  assign avail_next  = wr_bin_sync[ADDR_WIDTH:0] - rd_bin_next;
  assign empty_next  = rd_gray_next[ADDR_WIDTH:0] == wr_gray_sync[ADDR_WIDTH:0];
  assign aempty_next = avail_next <= (ADDR_WIDTH+1)'(AEMPTY);

  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_bin       <= '0;
      rd_gray      <= '0;
      wr_gray_meta <= '0;
      wr_gray_sync <= '0;
      empty        <= 1'b1;
      aempty       <= 1'b1;
    end else begin
      rd_bin       <= rd_bin_next;
      rd_gray      <= rd_gray_next;
      wr_gray_meta <= wr_gray;
      wr_gray_sync <= wr_gray_meta;
      empty        <= empty_next;
      aempty       <= aempty_next;
    end
  end

endmodule

/* verilog/wr_ptr_ctrl.sv */
module wr_ptr_ctrl #(
  parameter int DEPTH = 16,
  parameter int AFULL = DEPTH - 1,
  localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
  input  logic                   wr_clk,
  input  logic                   rd_rst_n,
  input  logic                   wr_en,
  input  cdc_ptr_pkg::gray_ptr_t rd_gray,
  output logic                   write,
  output logic [ADDR_WIDTH-1:0]  waddr,
  output cdc_ptr_pkg::gray_ptr_t wr_gray,
  output logic                   full,
  output logic                   afull
);

  // Top two Gray bits differ when the write side has lapped the read side
  localparam logic [ADDR_WIDTH:0] FULL_MASK = (ADDR_WIDTH+1)'(3) << (ADDR_WIDTH - 1);

  logic [1:0]             rst_sync;
  logic                   rst_n;
  logic [ADDR_WIDTH:0]    wr_bin;
  logic [ADDR_WIDTH:0]    wr_bin_next;
  cdc_ptr_pkg::gray_ptr_t wr_gray_next;
  cdc_ptr_pkg::gray_ptr_t rd_gray_meta;
  cdc_ptr_pkg::gray_ptr_t rd_gray_sync;
  cdc_ptr_pkg::ptr_t      rd_bin_sync;
  logic [ADDR_WIDTH:0]    used_next;
  logic                   full_next;
  logic                   afull_next;

  // Asynchronous assert, release on wr_clk
  always_ff @(posedge wr_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign rst_n = rst_sync[1];

  assign write        = wr_en & ~full;
  assign waddr        = wr_bin[ADDR_WIDTH-1:0];
  assign wr_bin_next  = wr_bin + (ADDR_WIDTH+1)'(write);
  assign wr_gray_next = cdc_ptr_pkg::bin2gray(cdc_ptr_pkg::ptr_t'(wr_bin_next));
  assign rd_bin_sync  = cdc_ptr_pkg::gray2bin(rd_gray_sync);

  // Stale read pointer keeps these conservative
  assign used_next  = wr_bin_next - rd_bin_sync[ADDR_WIDTH:0];
  assign full_next  = wr_gray_next[ADDR_WIDTH:0] == (rd_gray_sync[ADDR_WIDTH:0] ^ FULL_MASK);
  assign afull_next = used_next >= (ADDR_WIDTH+1)'(AFULL);

  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_bin       <= '0;
      wr_gray      <= '0;
      rd_gray_meta <= '0;
      rd_gray_sync <= '0;
      full         <= 1'b0;
      afull        <= 1'b0;
    end else begin
      wr_bin       <= wr_bin_next;
      wr_gray      <= wr_gray_next;
      rd_gray_meta <= rd_gray;
      rd_gray_sync <= rd_gray_meta;
      full         <= full_next;
      afull        <= afull_next;
    end
  end

endmodule
